//--- design/rayPkg.sv
`default_nettype none

package rayPkg;

	// ****************************************
	// Input and output formats
	// ****************************************

	// Signed coordinates x and y
	localparam int inWidth = 8;
	localparam int inFracWidth = 4;

	// Unsigned radius r
	localparam int outWidth = 8;
	localparam int outFracWidth = 4;

	// ****************************************
	// Internal datapath widths
	// ****************************************

	// A square keeps every product bit, the root halves them again later
	localparam int squareWidth = 2 * inWidth;
	localparam int squareFracWidth = 2 * inFracWidth;

	// Adding two squares needs one extra bit
	localparam int sumWidth = squareWidth + 1;

	// One root bit per pipeline stage
	localparam int sqrtWidth = (sumWidth + 1) / 2;
	localparam int sqrtFracWidth = squareFracWidth / 2;

	// Depth of the stream buffers around the datapath
	localparam int fifoDepth = 4;

	// Squarer, sum register, root stages and rescale register
	localparam int rayLatency = 3 + sqrtWidth;

endpackage

`default_nettype wire

//--- design/fracMultiplier.sv
`timescale 1ns/100ps
`default_nettype none

module fracMultiplier (
	input wire logic clk,
	input wire logic rstN,
	input wire logic en,
	input wire logic signed [rayPkg::inWidth-1:0] a,
	input wire logic signed [rayPkg::inWidth-1:0] b,
	output logic [rayPkg::squareWidth-1:0] result
);

	// The raw product carries twice the input fraction bits
	localparam int alignShift = 2 * rayPkg::inFracWidth - rayPkg::squareFracWidth;

	logic signed [rayPkg::squareWidth-1:0] product;
	logic signed [rayPkg::squareWidth-1:0] aligned;

	assign product = a * b;

	// Arithmetic shift so that a negative product keeps its sign
	assign aligned = product >>> alignShift;

	// Product register, frozen while the pipeline is stalled
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			result <= '0;
		end else if (en) begin
			result <= aligned;
		end
	end

endmodule

`default_nettype wire

//--- design/fixedSqrt.sv
`timescale 1ns/100ps
`default_nettype none

module fixedSqrt (
	input wire logic clk,
	input wire logic rstN,
	input wire logic en,
	input wire logic radicalValid,
	input wire logic [rayPkg::sumWidth-1:0] radical,
	output logic [rayPkg::sqrtWidth-1:0] q,
	output logic qValid
);

	localparam int stages = rayPkg::sqrtWidth;
	localparam int radWidth = 2 * stages;
	// Partial remainder never exceeds twice the partial root
	localparam int remWidth = stages + 2;

	// ****************************************
	// Stage registers
	// ****************************************

	logic [radWidth-1:0] radReg [stages];
	logic [remWidth-1:0] remReg [stages];
	logic [stages-1:0] rootReg [stages];
	logic [stages-1:0] validReg;

	logic [radWidth-1:0] radNext [stages];
	logic [remWidth-1:0] remNext [stages];
	logic [stages-1:0] rootNext [stages];

	logic [radWidth-1:0] radIn;
	logic [remWidth-1:0] remIn;
	logic [stages-1:0] rootIn;
	logic [remWidth+1:0] shifted;
	logic [remWidth+1:0] trial;
	logic [remWidth+1:0] diff;

	// ****************************************
	// Restoring step per stage
	// ****************************************

	always_comb begin
		for (int k = 0; k < stages; k++) begin
			int prev;
			prev = (k == 0) ? 0 : k - 1;
			if (k == 0) begin
				// The radical is padded to an even number of bits
				radIn = radWidth'(radical);
				remIn = '0;
				rootIn = '0;
			end else begin
				radIn = radReg[prev];
				remIn = remReg[prev];
				rootIn = rootReg[prev];
			end
			// Bring down the next bit pair, most significant pair first
			shifted = {remIn, radIn[2*(stages-1-k) +: 2]};
			trial = {2'b00, rootIn, 2'b01};
			diff = shifted - trial;
			if (shifted >= trial) begin
				remNext[k] = diff[remWidth-1:0];
				rootNext[k] = {rootIn[stages-2:0], 1'b1};
			end else begin
				remNext[k] = shifted[remWidth-1:0];
				rootNext[k] = {rootIn[stages-2:0], 1'b0};
			end
			radNext[k] = radIn;
		end
	end

	always_ff @(posedge clk) begin
		if (en) begin
			for (int k = 0; k < stages; k++) begin
				radReg[k] <= radNext[k];
				remReg[k] <= remNext[k];
				rootReg[k] <= rootNext[k];
			end
		end
	end

	// One valid bit travels alongside each radical
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			validReg <= '0;
		end else if (en) begin
			validReg <= {validReg[stages-2:0], radicalValid};
		end
	end

	assign q = rootReg[stages-1];
	assign qValid = validReg[stages-1];

endmodule

`default_nettype wire

//--- design/calcRay.sv
`timescale 1ns/100ps
`default_nettype none

module calcRay (
	input wire logic clk,
	input wire logic rstN,
	input wire logic inValid,
	output logic inReady,
	input wire logic signed [rayPkg::inWidth-1:0] x,
	input wire logic signed [rayPkg::inWidth-1:0] y,
	output logic outValid,
	input wire logic outReady,
	output logic [rayPkg::outWidth-1:0] r
);

	localparam int nOfInputs = 2;

	// Fraction alignment between the root and the output format
	localparam int upShift = (rayPkg::outFracWidth > rayPkg::sqrtFracWidth) ?
		rayPkg::outFracWidth - rayPkg::sqrtFracWidth : 0;
	localparam int downShift = (rayPkg::sqrtFracWidth > rayPkg::outFracWidth) ?
		rayPkg::sqrtFracWidth - rayPkg::outFracWidth : 0;
	localparam int scaleWidth = (rayPkg::sqrtWidth + upShift > rayPkg::outWidth) ?
		rayPkg::sqrtWidth + upShift : rayPkg::outWidth + 1;

	logic en;
	logic signed [rayPkg::inWidth-1:0] coord [nOfInputs];
	logic [rayPkg::squareWidth-1:0] square [nOfInputs];
	logic sqValid;
	logic [rayPkg::sumWidth-1:0] sum;
	logic sumValid;
	logic [rayPkg::sqrtWidth-1:0] root;
	logic rootValid;
	logic [scaleWidth-1:0] scaled;
	logic [rayPkg::outWidth-1:0] rNext;

	// ****************************************
	// Stall control
	// ****************************************

	// A result that cannot leave freezes every stage at once
	assign en = !(outValid && !outReady);
	assign inReady = en;

	// ****************************************
	// Squarers and sum
	// ****************************************

	assign coord[0] = x;
	assign coord[1] = y;

	for (genvar gi = 0; gi < nOfInputs; gi++) begin : squareGen
		fracMultiplier squarer (
			.clk(clk),
			.rstN(rstN),
			.en(en),
			.a(coord[gi]),
			.b(coord[gi]),
			.result(square[gi])
		);
	end

	always_ff @(posedge clk) begin
		if (en) begin
			sum <= {1'b0, square[0]} + {1'b0, square[1]};
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			sqValid <= 1'b0;
			sumValid <= 1'b0;
		end else if (en) begin
			sqValid <= inValid;
			sumValid <= sqValid;
		end
	end

	fixedSqrt sqrtFp (
		.clk(clk),
		.rstN(rstN),
		.en(en),
		.radicalValid(sumValid),
		.radical(sum),
		.q(root),
		.qValid(rootValid)
	);

	// ****************************************
	// Rescale and saturate
	// ****************************************

	assign scaled = (scaleWidth'(root) << upShift) >> downShift;
	// Any bit above the output width clips to the largest value
	assign rNext = (|scaled[scaleWidth-1:rayPkg::outWidth]) ? '1 :
		scaled[rayPkg::outWidth-1:0];

	always_ff @(posedge clk) begin
		if (en) begin
			r <= rNext;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else if (en) begin
			outValid <= rootValid;
		end
	end

endmodule

`default_nettype wire

//--- design/streamFifo.sv
`timescale 1ns/100ps
`default_nettype none

module streamFifo #(
	parameter type payloadType = logic [7:0]
) (
	input wire logic clk,
	input wire logic rstN,
	input wire logic inValid,
	output logic inReady,
	input wire payloadType inData,
	output logic outValid,
	input wire logic outReady,
	output payloadType outData
);

	localparam int ptrWidth = (rayPkg::fifoDepth > 1) ? $clog2(rayPkg::fifoDepth) : 1;
	localparam int countWidth = $clog2(rayPkg::fifoDepth + 1);
	localparam logic [ptrWidth-1:0] lastPtr = ptrWidth'(rayPkg::fifoDepth - 1);
	localparam logic [countWidth-1:0] fullCount = countWidth'(rayPkg::fifoDepth);

	payloadType mem [rayPkg::fifoDepth];
	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	logic [countWidth-1:0] count;
	logic push;
	logic pop;

	assign inReady = count != fullCount;
	assign outValid = count != '0;
	// Head entry is shown directly, so a write is visible one cycle later
	assign outData = mem[rdPtr];
	assign push = inValid && inReady;
	assign pop = outValid && outReady;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wrPtr] <= inData;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= (wrPtr == lastPtr) ? '0 : wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= (rdPtr == lastPtr) ? '0 : rdPtr + 1'b1;
			end
			// Simultaneous push and pop leaves the count unchanged
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/rayTop.sv
`timescale 1ns/100ps
`default_nettype none

module rayTop (
	input wire logic clk,
	input wire logic rstN,
	input wire logic inValid,
	output logic inReady,
	input wire logic signed [rayPkg::inWidth-1:0] x,
	input wire logic signed [rayPkg::inWidth-1:0] y,
	output logic rValid,
	input wire logic rReady,
	output logic [rayPkg::outWidth-1:0] r
);

	// Point stream between the input buffer and the datapath
	logic ptValid;
	logic ptReady;
	logic [2*rayPkg::inWidth-1:0] ptData;

	// Radius stream between the datapath and the output buffer
	logic resValid;
	logic resReady;
	logic [rayPkg::outWidth-1:0] resData;

	// x travels in the upper half of the point word
	streamFifo #(
		.payloadType(logic [2*rayPkg::inWidth-1:0])
	) pointFifo (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inReady(inReady),
		.inData({x, y}),
		.outValid(ptValid),
		.outReady(ptReady),
		.outData(ptData)
	);

	calcRay rayCalc (
		.clk(clk),
		.rstN(rstN),
		.inValid(ptValid),
		.inReady(ptReady),
		.x(ptData[2*rayPkg::inWidth-1 -: rayPkg::inWidth]),
		.y(ptData[rayPkg::inWidth-1:0]),
		.outValid(resValid),
		.outReady(resReady),
		.r(resData)
	);

	streamFifo #(
		.payloadType(logic [rayPkg::outWidth-1:0])
	) radiusFifo (
		.clk(clk),
		.rstN(rstN),
		.inValid(resValid),
		.inReady(resReady),
		.inData(resData),
		.outValid(rValid),
		.outReady(rReady),
		.outData(r)
	);

endmodule

`default_nettype wire

//--- sim/calcRay_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module calcRayAsserts (
	input wire logic clk,
	input wire logic rstN,
	input wire logic inValid,
	input wire logic inReady,
	input wire logic signed [rayPkg::inWidth-1:0] x,
	input wire logic signed [rayPkg::inWidth-1:0] y,
	input wire logic outValid,
	input wire logic outReady,
	input wire logic [rayPkg::outWidth-1:0] r
);

	// A stalled result keeps its valid and its value
	holdWhileStalled: assert property (@(posedge clk) disable iff (!rstN)
		outValid && !outReady |=> outValid && $stable(r))
		else $error("calcRay changed its result while the output was stalled");

	resetClearsValid: assert property (@(posedge clk) !rstN |-> !outValid)
		else $error("calcRay outValid was high during reset");

	// A point held back by a stall stays offered and unchanged
	inputHeldWhileBlocked: assert property (@(posedge clk) disable iff (!rstN)
		inValid && !inReady |=> inValid && $stable(x) && $stable(y))
		else $error("calcRay input point changed before it was accepted");

endmodule

bind calcRay calcRayAsserts asserts (.*);

`default_nettype wire

//--- sim/tbRay.sv
`timescale 1ns/100ps
`default_nettype none

module tbRay;

	localparam int randCount = 200;
	// Rough cycle need of all six tests with gaps and back-pressure
	localparam int neededCycles = 2500;
	localparam int maxCycles = 8 * neededCycles;

	logic clk;
	logic rstN;
	logic inValid;
	logic inReady;
	logic signed [rayPkg::inWidth-1:0] x;
	logic signed [rayPkg::inWidth-1:0] y;
	logic rValid;
	logic rReady;
	logic [rayPkg::outWidth-1:0] r;

	int expQ [$];
	string testName;
	int testErrors;
	int checkCount;
	int totalErrors;
	int totalChecks;
	int testCount;
	int cycles;
	logic [31:0] stimState;
	logic [31:0] readyState;
	logic readyRandom;
	int xr;
	int yr;
	int gap;
	int magX [3] = '{48, 25, 100};
	int magY [3] = '{64, 60, 17};

	rayTop u_dut (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inReady(inReady),
		.x(x),
		.y(y),
		.rValid(rValid),
		.rReady(rReady),
		.r(r)
	);

	// ****************************************
	// Reference model and random source
	// ****************************************

	// Raw inputs carry inFracWidth fraction bits, the root of their square sum sqrtFracWidth
	function automatic int refRadius(input int xRaw, input int yRaw, input int outBits);
		int sumSq;
		int root;
		int maxOut;
		sumSq = xRaw * xRaw + yRaw * yRaw;
		root = 0;
		while ((root + 1) * (root + 1) <= sumSq) begin
			root++;
		end
		if (rayPkg::outFracWidth >= rayPkg::sqrtFracWidth) begin
			root = root << (rayPkg::outFracWidth - rayPkg::sqrtFracWidth);
		end else begin
			root = root >> (rayPkg::sqrtFracWidth - rayPkg::outFracWidth);
		end
		maxOut = (1 << outBits) - 1;
		return (root > maxOut) ? maxOut : root;
	endfunction

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic randomPoint();
		stimState = lcgNext(stimState);
		xr = int'($signed(stimState[31:24]));
		yr = int'($signed(stimState[23:16]));
		gap = int'(stimState[9:8]);
	endtask

	// ****************************************
	// Stimulus helpers
	// ****************************************

	// Called 1 ns after an edge, returns 1 ns after the accepting edge
	task automatic sendPoint(input int xv, input int yv);
		inValid = 1'b1;
		x = xv[rayPkg::inWidth-1:0];
		y = yv[rayPkg::inWidth-1:0];
		@(posedge clk);
		while (!inReady) @(posedge clk);
		#1;
	endtask

	task automatic idleCycles(input int n);
		inValid = 1'b0;
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic startTest(input string name);
		testName = name;
		testErrors = 0;
		checkCount = 0;
	endtask

	task automatic endTest();
		inValid = 1'b0;
		while (expQ.size() != 0) @(posedge clk);
		// Any surplus output after the last expected one is caught by the checker
		repeat (rayPkg::rayLatency + 4) @(posedge clk);
		#1;
		$display("Test %s finished: %0d checked, %0d errors", testName, checkCount, testErrors);
		totalErrors += testErrors;
		totalChecks += checkCount;
		testCount++;
	endtask

	// ****************************************
	// Clock, ready pattern, scoreboard, timeout
	// ****************************************

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		rReady = 1'b0;
		readyState = 32'hf293979b ^ 32'h5a5a5a5a;
		forever begin
			@(posedge clk);
			#1;
			readyState = lcgNext(readyState);
			rReady = readyRandom ? readyState[31] : 1'b1;
		end
	end

	always @(posedge clk) begin
		int expected;
		if (rstN && inValid && inReady) begin
			expQ.push_back(refRadius(int'(x), int'(y), rayPkg::outWidth));
		end
		if (rstN && rValid && rReady) begin
			if (expQ.size() == 0) begin
				$display("Test %s got radius %0d with no point outstanding", testName, r);
				testErrors++;
			end else begin
				expected = expQ.pop_front();
				checkCount++;
				if (int'(r) != expected) begin
					$display("Mismatch in %s: expected %0d, actual %0d", testName, expected, r);
					testErrors++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= maxCycles) begin
			$display("Timeout: test %s did not finish within %0d cycles", testName, maxCycles);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// ****************************************
	// Test sequence
	// ****************************************

	initial begin
		rstN = 1'b0;
		inValid = 1'b0;
		x = '0;
		y = '0;
		readyRandom = 1'b0;
		stimState = 32'hf293979b;
		totalErrors = 0;
		totalChecks = 0;
		testCount = 0;
		cycles = 0;
		startTest("reset");
		repeat (4) @(posedge clk);
		#1;
		rstN = 1'b1;

		// Values are raw, 16 steps per unit
		startTest("axis");
		sendPoint(0, 0);
		sendPoint(48, 0);
		sendPoint(0, -80);
		sendPoint(48, 64);
		sendPoint(-12, 16);
		endTest();

		startTest("signs");
		for (int m = 0; m < 3; m++) begin
			for (int s = 0; s < 4; s++) begin
				sendPoint(s[0] ? -magX[m] : magX[m], s[1] ? -magY[m] : magY[m]);
			end
		end
		endTest();

		startTest("fullRate");
		repeat (randCount) begin
			randomPoint();
			sendPoint(xr, yr);
		end
		endTest();

		startTest("backPressure");
		readyRandom = 1'b1;
		repeat (randCount) begin
			randomPoint();
			sendPoint(xr, yr);
			if (gap != 0)
				idleCycles(gap);
		end
		endTest();
		readyRandom = 1'b0;

		startTest("extremes");
		sendPoint(-128, -128);
		sendPoint(127, -128);
		sendPoint(-128, 127);
		sendPoint(127, 127);
		if (refRadius(-128, -128, rayPkg::outWidth) >= (1 << rayPkg::outWidth) - 1) begin
			$display("Largest corner radius clips at the default output width");
			testErrors++;
		end
		// Two bits fewer at the output must clip the same corner to full scale
		if (refRadius(-128, -128, rayPkg::outWidth - 2) != (1 << (rayPkg::outWidth - 2)) - 1) begin
			$display("Mismatch in %s: expected %0d, actual %0d", testName,
				(1 << (rayPkg::outWidth - 2)) - 1, refRadius(-128, -128, rayPkg::outWidth - 2));
			testErrors++;
		end
		endTest();

		startTest("midReset");
		// Long enough that results are already leaving when reset hits
		repeat (rayPkg::rayLatency + 8) begin
			randomPoint();
			sendPoint(xr, yr);
		end
		inValid = 1'b0;
		rstN = 1'b0;
		expQ.delete();
		repeat (2) @(posedge clk);
		if (rValid !== 1'b0) begin
			$display("Test %s: rValid stayed high while reset was asserted", testName);
			testErrors++;
		end
		#1;
		rstN = 1'b1;
		repeat (10) begin
			randomPoint();
			sendPoint(xr, yr);
		end
		endTest();

		$display("Summary: %0d tests, %0d checks, %0d errors", testCount, totalChecks, totalErrors);
		if (totalErrors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
design/rayPkg.sv
design/fracMultiplier.sv
design/fixedSqrt.sv
design/calcRay.sv
design/streamFifo.sv
design/rayTop.sv
sim/calcRay_asserts.sv
sim/tbRay.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = tbRay
FILELIST = project.f
OBJDIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# The status of grep decides pass or fail
run: compile
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "^STATUS: PASS$$"

clean:
	rm -rf $(OBJDIR)
